/* Makefile */
TOP := tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
design/icache_pkg.sv
design/wb_pkg.sv
design/icache_if.sv
design/icache_tag_lookup.sv
design/icache_refill.sv
design/icache_fetch_result.sv
design/icache_top.sv
tb/tb_icache_mem.sv
tb/tb_icache.sv

/* design/icache_fetch_result.sv */
module icache_fetch_result (
	input  logic                         clk,
	input  logic                         rst,
	output logic                         rsp_valid,
	output logic [icache_pkg::inst_w-1:0] rsp_inst,
	input  logic                         rsp_ready,
	input  logic                         flush,
	lookup_if.result                     lk,
	fill_if.sink                         fl
);
	import icache_pkg::*;

	// one line array per way
	line_t data_q [num_ways][num_sets];

	line_t hit_line;
	logic [inst_w-1:0] hit_word;
	logic [inst_w-1:0] fill_word;
	// miss accepted and its answer still wanted
	logic miss_wait_q;
	logic out_free;

	// empty, or drained at this edge
	assign out_free = !rsp_valid || rsp_ready;
	assign fl.out_free = out_free;

	// way mux on the registered hit vector
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (lk.hit_way[w]) begin
				hit_line = hit_line | data_q[w][lk.index];
			end
		end
	end

	// word select by offset
	assign hit_word = hit_line[lk.offset[offset_w-1:2]];
	// missed word straight from the new line
	assign fill_word = fl.fill_line[fl.fill_offset[offset_w-1:2]];

	// line writes from refill
	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (fl.fill_valid && fl.fill_way[w]) begin
				data_q[w][fl.fill_index] <= fl.fill_line;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
			miss_wait_q <= 1'b0;
		end else if (flush) begin
			// drop whatever is in flight
			rsp_valid <= 1'b0;
			miss_wait_q <= 1'b0;
		end else begin
			if (lk.miss) begin
				miss_wait_q <= 1'b1;
			end else if (fl.fill_valid) begin
				miss_wait_q <= 1'b0;
			end
			// hold under stall
			if (out_free) begin
				rsp_valid <= lk.hit || (fl.fill_valid && miss_wait_q);
			end
		end
	end

	// response word
	always_ff @(posedge clk) begin
		if (out_free) begin
			if (lk.hit) begin
				rsp_inst <= hit_word;
			end else if (fl.fill_valid) begin
				rsp_inst <= fill_word;
			end
		end
	end

	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		(rsp_valid && !rsp_ready && !flush) |=> (rsp_valid && $stable(rsp_inst)));
	// refill only answers into a free slot
	a_fill_slot: assert property (@(posedge clk) disable iff (rst)
		(fl.fill_valid && miss_wait_q) |-> out_free);

endmodule

/* design/icache_if.sv */
// lookup stage result, read by refill and response stage
interface lookup_if;
	import icache_pkg::*;

	logic hit;
	logic miss;
	way_t hit_way;
	logic [index_w-1:0] index;
	logic [offset_w-1:0] offset;
	logic [tag_w-1:0] tag;
	way_t victim_way;
	// refill in progress, blocks new lookups
	logic busy;

	modport lookup (output hit, miss, hit_way, index, offset, tag, victim_way, input busy);
	modport refill (input miss, index, offset, tag, victim_way, output busy);
	modport result (input hit, miss, hit_way, index, offset);
endinterface

// finished line from refill to tag and data arrays
interface fill_if;
	import icache_pkg::*;

	logic fill_valid;
	way_t fill_way;
	logic [index_w-1:0] fill_index;
	logic [tag_w-1:0] fill_tag;
	line_t fill_line;
	logic [offset_w-1:0] fill_offset;
	// response register can load at next edge
	logic out_free;

	modport source (output fill_valid, fill_way, fill_index, fill_tag, fill_line, fill_offset,
		input out_free);
	modport sink (input fill_valid, fill_way, fill_index, fill_line, fill_offset, output out_free);
	modport tag (input fill_valid, fill_way, fill_index, fill_tag, out_free);
endinterface

/* design/icache_pkg.sv */
package icache_pkg;

	// fetch address and instruction widths
	localparam int addr_w = 32;
	localparam int inst_w = 32;

	// 4-way set associative, 64 sets of 16-byte lines
	localparam int num_ways = 4;
	localparam int num_sets = 64;
	localparam int index_w = 6;
	localparam int offset_w = 4;
	// everything above index and offset
	localparam int tag_w = addr_w - index_w - offset_w;
	localparam int words_per_line = 4;

	// whole line, word 0 in the low bits
	typedef logic [words_per_line-1:0][inst_w-1:0] line_t;
	// one-hot way select
	typedef logic [num_ways-1:0] way_t;

	// miss sequencer
	typedef enum logic [1:0] {
		refill_idle,
		refill_bus,
		refill_write,
		refill_answer
	} refill_state_e;

endpackage

/* design/icache_refill.sv */
module icache_refill (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            flush,
	lookup_if.refill                        lk,
	fill_if.source                          fl,
	output logic                            wb_cyc,
	output logic                            wb_stb,
	output logic                            wb_we,
	output logic [wb_pkg::wb_addr_w-1:0]    wb_adr,
	output logic [wb_pkg::wb_data_w/8-1:0]  wb_sel,
	input  logic [wb_pkg::wb_data_w-1:0]    wb_dat_i,
	input  logic                            wb_ack
);
	import icache_pkg::*;
	import wb_pkg::*;

	refill_state_e state_q;
	// cycle the master has open on the bus
	wb_cycle_e kind_q;
	// word of the line being fetched
	logic [$clog2(wb_beats)-1:0] beat_q;
	// flush seen so the line lands without an answer
	logic cancel_q;

	// miss context
	logic [index_w-1:0] index_q;
	logic [tag_w-1:0] tag_q;
	logic [offset_w-1:0] offset_q;
	way_t way_q;
	line_t line_q;

	// read-only master on full word lanes
	assign wb_cyc = (kind_q == wb_read);
	assign wb_stb = wb_cyc;
	assign wb_we = 1'b0;
	assign wb_sel = '1;
	// line-aligned base plus word number and zero byte bits
	assign wb_adr = {tag_q, index_q, beat_q, 2'b00};

	assign lk.busy = (state_q != refill_idle);

	// cancelled answer needs no response slot
	assign fl.fill_valid = (state_q == refill_write) && (fl.out_free || cancel_q);
	assign fl.fill_way = way_q;
	assign fl.fill_index = index_q;
	assign fl.fill_tag = tag_q;
	assign fl.fill_line = line_q;
	assign fl.fill_offset = offset_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= refill_idle;
			kind_q <= wb_none;
			beat_q <= '0;
			cancel_q <= 1'b0;
		end else begin
			if (flush && state_q != refill_idle) begin
				cancel_q <= 1'b1;
			end
			case (state_q)
				refill_idle: begin
					// first read opens one cycle after the miss pulse
					if (lk.miss) begin
						state_q <= refill_bus;
						kind_q <= wb_read;
						beat_q <= '0;
						cancel_q <= flush;
					end
				end
				refill_bus: begin
					if (wb_cyc && wb_ack) begin
						// close the cycle for one idle clock between beats
						kind_q <= wb_none;
						// all ones marks the last word
						if (&beat_q) begin
							state_q <= refill_write;
						end else begin
							beat_q <= beat_q + 1'b1;
						end
					end else if (!wb_cyc) begin
						kind_q <= wb_read;
					end
				end
				refill_write: begin
					// wait here while the response register is stalled
					if (fl.fill_valid) begin
						state_q <= refill_answer;
					end
				end
				refill_answer: begin
					// answer loads into the response register
					state_q <= refill_idle;
				end
				default: begin
					state_q <= refill_idle;
				end
			endcase
		end
	end

	// latch miss context and pack returned words
	always_ff @(posedge clk) begin
		if (state_q == refill_idle && lk.miss) begin
			index_q <= lk.index;
			tag_q <= lk.tag;
			offset_q <= lk.offset;
			way_q <= lk.victim_way;
		end
		if (wb_cyc && wb_ack) begin
			line_q[beat_q] <= wb_dat_i;
		end
	end

	a_stb_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);
	// request held with a steady address until acked
	a_adr_stable: assert property (@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));
	// bus cycles only while gathering a line
	a_cycle_kind: assert property (@(posedge clk) disable iff (rst)
		(kind_q != wb_none) |-> (state_q == refill_bus));

endmodule

/* design/icache_tag_lookup.sv */
module icache_tag_lookup (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         req_valid,
	input  logic [icache_pkg::addr_w-1:0] req_addr,
	output logic                         req_ready,
	input  logic                         flush,
	input  logic                         invalidate,
	lookup_if.lookup                     lk,
	fill_if.tag                          fl
);
	import icache_pkg::*;

	// per-way tag arrays and valid vectors
	logic [tag_w-1:0] tag_q [num_ways][num_sets];
	logic [num_sets-1:0] valid_q [num_ways];

	logic [tag_w-1:0] req_tag;
	logic [index_w-1:0] req_index;
	logic [offset_w-1:0] req_offset;
	way_t hit_vec;
	way_t victim_q;
	// low through reset, high from the first cycle after
	logic run_q;
	logic accept;

	// address split
	assign req_tag = req_addr[addr_w-1 -: tag_w];
	assign req_index = req_addr[offset_w +: index_w];
	assign req_offset = req_addr[offset_w-1:0];

	// compare all ways in parallel
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			hit_vec[w] = valid_q[w][req_index] && (tag_q[w][req_index] == req_tag);
		end
	end

	// response slot free, no refill pending or starting, no flush or invalidate
	assign req_ready = run_q && fl.out_free && !lk.busy && !lk.miss && !flush && !invalidate;
	assign accept = req_valid && req_ready;

	assign lk.victim_way = victim_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			run_q <= 1'b0;
			lk.hit <= 1'b0;
			lk.miss <= 1'b0;
			victim_q <= way_t'(1);
			for (int w = 0; w < num_ways; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			run_q <= 1'b1;
			lk.miss <= accept && (hit_vec == '0);
			// hit stays in the stage until the response register takes it
			if (flush) begin
				lk.hit <= 1'b0;
			end else if (fl.out_free) begin
				lk.hit <= accept && (hit_vec != '0);
			end
			// rotate victim on every line fill
			if (fl.fill_valid) begin
				victim_q <= {victim_q[num_ways-2:0], victim_q[num_ways-1]};
			end
			// invalidate only between refills
			if (invalidate && !lk.busy) begin
				for (int w = 0; w < num_ways; w++) begin
					valid_q[w] <= '0;
				end
			end else if (fl.fill_valid) begin
				for (int w = 0; w < num_ways; w++) begin
					if (fl.fill_way[w]) begin
						valid_q[w][fl.fill_index] <= 1'b1;
					end
				end
			end
		end
	end

	// lookup fields and tag writes
	always_ff @(posedge clk) begin
		if (accept) begin
			lk.hit_way <= hit_vec;
			lk.index <= req_index;
			lk.offset <= req_offset;
			lk.tag <= req_tag;
		end
		for (int w = 0; w < num_ways; w++) begin
			if (fl.fill_valid && fl.fill_way[w]) begin
				tag_q[w][fl.fill_index] <= fl.fill_tag;
			end
		end
	end

	// a line lives in one way only, so at most one way matches
	a_hit_way_onehot: assert property (@(posedge clk) disable iff (rst)
		(lk.hit || lk.miss) |-> $onehot0(lk.hit_way));
	a_hit_miss_excl: assert property (@(posedge clk) disable iff (rst)
		!(lk.hit && lk.miss));

endmodule

/* design/icache_top.sv */
module icache_top (
	input  logic                            clk,
	input  logic                            rst,
	// core request
	input  logic                            req_valid,
	input  logic [icache_pkg::addr_w-1:0]   req_addr,
	output logic                            req_ready,
	// core response
	output logic                            rsp_valid,
	output logic [icache_pkg::inst_w-1:0]   rsp_inst,
	input  logic                            rsp_ready,
	// pipeline flush and cache invalidate
	input  logic                            flush,
	input  logic                            invalidate,
	// wishbone classic master
	output logic                            wb_cyc,
	output logic                            wb_stb,
	output logic                            wb_we,
	output logic [wb_pkg::wb_addr_w-1:0]    wb_adr,
	output logic [wb_pkg::wb_data_w/8-1:0]  wb_sel,
	input  logic [wb_pkg::wb_data_w-1:0]    wb_dat_i,
	input  logic                            wb_ack
);

	// lookup result to refill and response stage
	lookup_if lk_if ();
	// finished line to tag and data arrays
	fill_if fl_if ();

	// tags, hit decode, victim, request acceptance
	icache_tag_lookup i_tag_lookup (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_ready  (req_ready),
		.flush      (flush),
		.invalidate (invalidate),
		.lk         (lk_if.lookup),
		.fl         (fl_if.tag)
	);

	// line refill over the bus
	icache_refill i_refill (
		.clk      (clk),
		.rst      (rst),
		.flush    (flush),
		.lk       (lk_if.refill),
		.fl       (fl_if.source),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_sel   (wb_sel),
		.wb_dat_i (wb_dat_i),
		.wb_ack   (wb_ack)
	);

	// data arrays and response register
	icache_fetch_result i_fetch_result (
		.clk       (clk),
		.rst       (rst),
		.rsp_valid (rsp_valid),
		.rsp_inst  (rsp_inst),
		.rsp_ready (rsp_ready),
		.flush     (flush),
		.lk        (lk_if.result),
		.fl        (fl_if.sink)
	);

endmodule

/* design/wb_pkg.sv */
package wb_pkg;

	// classic bus widths
	localparam int wb_addr_w = 32;
	localparam int wb_data_w = 32;

	// one line refill = four single-word reads
	localparam int wb_beats = 4;

	// kind of cycle the master has open
	typedef enum logic {
		wb_none,
		wb_read
	} wb_cycle_e;

endpackage

/* tb/tb_icache.sv */
module tb_icache;
	timeunit 1ns;
	timeprecision 1ps;
	import icache_pkg::*;

	localparam logic [31:0] lfsr_seed = 32'h2ee3;
	// memory word is its word address xor this
	localparam logic [31:0] data_xor = 32'h5a3c_96e1;
	localparam int num_random = 500;
	// worst miss in cycles with three waits per beat and some stall
	localparam int worst_miss = 24;
	localparam int cycle_limit = (num_random + 16) * worst_miss * 2;
	// set 35 with a tag that random traffic never uses
	localparam logic [31:0] lost_addr = 32'h7ff0_0a38;

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	logic [addr_w-1:0] req_addr;
	logic req_ready;
	logic rsp_valid;
	logic [inst_w-1:0] rsp_inst;
	logic rsp_ready;
	logic flush;
	logic invalidate;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [3:0] wb_sel;
	logic [31:0] wb_dat_i;
	logic wb_ack;

	logic [31:0] lfsr_q = lfsr_seed;
	// per-cycle draw with valid in 1:0, address in 8:2, ready in 10:9 and flush in 16:11
	logic [16:0] stim_bits = '0;
	logic [1:0] wait_sel = '0;
	int cycles = 0;
	int errors = 0;
	int end_errors = 0;
	int accepted = 0;
	int answered = 0;
	int refills = 0;

	// accepted and not yet answered in request order
	logic [addr_w-1:0] pending [$];
	// word addresses the model expects on the bus
	logic [31:0] bus_exp [$];

	// reference cache with one global round-robin victim
	logic [tag_w-1:0] m_tag [num_ways][num_sets];
	logic m_valid [num_ways][num_sets];
	logic [1:0] m_victim = 2'd0;

	// previous-sample monitor state
	logic stall_q = 1'b0;
	logic [inst_w-1:0] held_q = '0;
	logic bus_wait_q = 1'b0;
	logic ack_q = 1'b0;
	logic [31:0] adr_q = '0;

	icache_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_ready  (req_ready),
		.rsp_valid  (rsp_valid),
		.rsp_inst   (rsp_inst),
		.rsp_ready  (rsp_ready),
		.flush      (flush),
		.invalidate (invalidate),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_sel     (wb_sel),
		.wb_dat_i   (wb_dat_i),
		.wb_ack     (wb_ack)
	);

	tb_icache_mem #(.data_xor(data_xor)) i_mem (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_adr   (wb_adr),
		.wb_dat_o (wb_dat_i),
		.wb_ack   (wb_ack),
		.wait_sel (wait_sel)
	);

	always #20 clk = ~clk;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			bits = {bits[30:0], lfsr_q[0]};
		end
		return bits;
	endfunction

	// 8 tags over sets 0..3 so a set sees more tags than ways
	function automatic logic [addr_w-1:0] addr_from_bits(input logic [6:0] b);
		logic [tag_w-1:0] tag;
		tag = 22'h01200 + {19'd0, b[6:4]};
		return {tag, 4'b0000, b[3:2], b[1:0], 2'b00};
	endfunction

	// instruction the memory holds for a fetch address
	function automatic logic [inst_w-1:0] expected_inst(input logic [addr_w-1:0] addr);
		return {addr[addr_w-1:2], 2'b00} ^ data_xor;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] want,
		input logic [31:0] got);
		errors++;
		$display("[ERROR] %0d ns %s expected %h got %h", $time, name, want, got);
	endtask

	task automatic report_fault(input string what);
		errors++;
		$display("error at %0d ns: %s", $time, what);
	endtask

	task automatic clear_model();
		for (int w = 0; w < num_ways; w++) begin
			for (int s = 0; s < num_sets; s++) begin
				m_valid[w][s] = 1'b0;
			end
		end
	endtask

	// lookup that on a miss installs in the victim way and predicts 4 reads
	task automatic model_access(input logic [addr_w-1:0] addr);
		logic [tag_w-1:0] tag;
		logic [index_w-1:0] index;
		logic hit;
		tag = addr[addr_w-1 -: tag_w];
		index = addr[offset_w +: index_w];
		hit = 1'b0;
		for (int w = 0; w < num_ways; w++) begin
			if (m_valid[w][index] && m_tag[w][index] == tag) begin
				hit = 1'b1;
			end
		end
		if (!hit) begin
			m_tag[m_victim][index] = tag;
			m_valid[m_victim][index] = 1'b1;
			m_victim = m_victim + 2'd1;
			refills++;
			for (int b = 0; b < words_per_line; b++) begin
				bus_exp.push_back({addr[addr_w-1:offset_w], 2'(b), 2'b00});
			end
		end
	endtask

	// random source for stimulus and memory waits
	always @(posedge clk) begin
		#1;
		wait_sel = 2'(take_bits(2));
		stim_bits = 17'(take_bits(17));
	end

	// run limit in clock cycles
	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("FAIL: see errors above");
		$finish;
	end

	// checker sampling mid-cycle what the next edge will do
	always @(negedge clk) begin
		logic [inst_w-1:0] want_inst;
		logic [31:0] want_adr;
		if (rst) begin
			clear_model();
			m_victim = 2'd0;
			stall_q = 1'b0;
			bus_wait_q = 1'b0;
			ack_q = 1'b0;
		end else begin
			// response handshake in request order
			if (rsp_valid && rsp_ready) begin
				assert (pending.size() != 0) else begin
					report_fault("response with no request outstanding");
				end
				if (pending.size() != 0) begin
					want_inst = expected_inst(pending.pop_front());
					answered++;
					assert (rsp_inst == want_inst) else begin
						report_mismatch("rsp_inst", want_inst, rsp_inst);
					end
				end
			end
			// stalled answer must hold
			if (stall_q) begin
				assert (rsp_valid) else begin
					report_fault("rsp_valid dropped while stalled");
				end
				assert (rsp_inst == held_q) else begin
					report_mismatch("rsp_inst", held_q, rsp_inst);
				end
			end
			stall_q = rsp_valid && !rsp_ready && !flush;
			held_q = rsp_inst;
			// flush drops everything in flight
			if (flush) begin
				pending.delete();
			end
			if (invalidate) begin
				clear_model();
			end
			if (req_valid && req_ready) begin
				accepted++;
				pending.push_back(req_addr);
				model_access(req_addr);
			end
			// bus protocol
			assert (!wb_stb || wb_cyc) else begin
				report_fault("wishbone stb high without cyc");
			end
			assert (!wb_we) else begin
				report_fault("wishbone we high on a read-only master");
			end
			if (wb_cyc) begin
				assert (wb_sel == 4'hf) else begin
					report_mismatch("wb_sel", 32'hf, 32'(wb_sel));
				end
			end
			if (ack_q) begin
				assert (!wb_cyc) else begin
					report_fault("wishbone cycle not closed for a clock after ack");
				end
			end
			if (bus_wait_q) begin
				assert (wb_cyc && wb_stb && wb_adr == adr_q) else begin
					report_fault("wishbone request dropped or address changed before ack");
				end
			end
			if (wb_cyc && wb_stb && wb_ack) begin
				assert (bus_exp.size() != 0) else begin
					report_fault("wishbone read that the reference cache did not predict");
				end
				if (bus_exp.size() != 0) begin
					want_adr = bus_exp.pop_front();
					assert (wb_adr == want_adr) else begin
						report_mismatch("wb_adr", want_adr, wb_adr);
					end
				end
			end
			bus_wait_q = wb_cyc && wb_stb && !wb_ack;
			ack_q = wb_cyc && wb_stb && wb_ack;
			adr_q = wb_adr;
		end
	end

	// one request held until accepted
	task automatic fetch(input logic [addr_w-1:0] addr);
		req_valid = 1'b1;
		req_addr = addr;
		@(negedge clk);
		while (!req_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	// wait for all answers, predicted refills and an idle lookup
	task automatic wait_idle();
		@(negedge clk);
		while (pending.size() != 0 || bus_exp.size() != 0 || !req_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic run_random(input int count);
		int taken;
		logic take;
		taken = 0;
		while (taken < count) begin
			@(negedge clk);
			take = req_valid && req_ready;
			if (take) begin
				taken++;
			end
			@(posedge clk);
			#2;
			// address held until the handshake
			if (!req_valid || take) begin
				req_valid = (stim_bits[1:0] != 2'b00) && (taken < count);
				req_addr = addr_from_bits(stim_bits[8:2]);
			end
			rsp_ready = stim_bits[10:9] != 2'b00;
			flush = stim_bits[16:11] == 6'd0;
		end
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		rsp_ready = 1'b0;
		flush = 1'b0;
		invalidate = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		run_random(num_random);
		rsp_ready = 1'b1;
		flush = 1'b0;
		wait_idle();

		// miss dropped by flush while its line still lands
		fetch(lost_addr);
		flush = 1'b1;
		@(posedge clk);
		#2;
		flush = 1'b0;
		wait_idle();
		fetch(lost_addr);
		wait_idle();

		// five tags into set 9 and then the first again
		for (int t = 0; t < 5; t++) begin
			fetch({22'h002a0 + 22'(t), 6'd9, 4'h4});
		end
		fetch({22'h002a0, 6'd9, 4'h8});
		wait_idle();

		// everything refills after invalidate
		invalidate = 1'b1;
		@(posedge clk);
		#2;
		invalidate = 1'b0;
		fetch(lost_addr);
		fetch({22'h002a4, 6'd9, 4'h0});
		for (int i = 0; i < 4; i++) begin
			fetch(addr_from_bits(stim_bits[8:2]));
		end
		wait_idle();

		assert (pending.size() == 0) else begin
			end_errors++;
			$display("accepted requests were never answered");
		end
		assert (bus_exp.size() == 0) else begin
			end_errors++;
			$display("predicted refills never appeared on the bus");
		end
		$display("summary: %0d accepted, %0d answered, %0d refills, %0d bus reads, %0d errors",
			accepted, answered, refills, i_mem.reads, errors + end_errors);
		if (errors + end_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* tb/tb_icache_mem.sv */
module tb_icache_mem #(
	parameter logic [wb_pkg::wb_data_w-1:0] data_xor = '0
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic [wb_pkg::wb_addr_w-1:0] wb_adr,
	output logic [wb_pkg::wb_data_w-1:0] wb_dat_o,
	output logic                         wb_ack,
	// wait cycles for the next new request
	input  logic [1:0]                   wait_sel
);
	timeunit 1ns;
	timeprecision 1ps;

	int waits_left = 0;
	// request seen, wait count loaded
	logic started = 1'b0;
	int reads = 0;

	initial begin
		wb_ack = 1'b0;
		wb_dat_o = '0;
	end

	// acts on post-edge bus values, drives just after the edge
	always begin
		@(posedge clk);
		#2;
		if (rst) begin
			wb_ack = 1'b0;
			started = 1'b0;
		end else if (wb_ack) begin
			// single-cycle ack, master closes at that edge
			wb_ack = 1'b0;
			wb_dat_o = '0;
		end else if (wb_cyc && wb_stb) begin
			if (!started) begin
				started = 1'b1;
				waits_left = int'(wait_sel);
			end
			if (waits_left == 0) begin
				wb_ack = 1'b1;
				// word is a fixed function of the whole address
				wb_dat_o = wb_adr ^ data_xor;
				started = 1'b0;
				reads++;
			end else begin
				waits_left--;
			end
		end
	end

endmodule
